// File: src/rv32_ctrl_pkg.sv
// Field widths, encodings, control word layout and decode tables shared by the RV32I control decoder
package rv32_ctrl_pkg;

    localparam int xlen         = 32;                             // Instruction width
    localparam int opcode_w     = 7;
    localparam int funct3_w     = 3;
    localparam int funct7_w     = 7;
    localparam int ctrl_key_w   = opcode_w + funct3_w + funct7_w; // opcode_funct3_funct7
    localparam int mem_key_w    = opcode_w + funct3_w;            // opcode_funct3
    localparam int nr_ctrl_keys = 37;
    localparam int nr_mem_keys  = 8;

    typedef enum logic [opcode_w-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD = 5'd0, ALU_SUB = 5'd1, ALU_SLT = 5'd2, ALU_SLTU = 5'd3, ALU_XOR = 5'd4,
        ALU_OR  = 5'd5, ALU_AND = 5'd6, ALU_SLL = 5'd7, ALU_SRL  = 5'd8, ALU_SRA = 5'd9
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1 = 2'd0, OP1_PC = 2'd1} op1_sel_e;
    typedef enum logic [1:0] {OP2_NONE = 2'd0, OP2_IMM_I = 2'd1, OP2_IMM_S = 2'd2, OP2_RS2 = 2'd3} op2_sel_e;
    typedef enum logic [2:0] {
        PC_SEQ = 3'd0, PC_JALR_TGT = 3'd1, PC_BRANCH_TGT = 3'd2, PC_JAL_TGT = 3'd3
    } pc_sel_e;
    typedef enum logic [1:0] {WB_NONE = 2'd0, WB_PC4 = 2'd1, WB_ALU = 2'd2, WB_MEM = 2'd3} wb_sel_e;

    // Bit 2 marks zero extension on loads
    typedef enum logic [2:0] {
        MEM_BYTE = 3'b000, MEM_HALF = 3'b001, MEM_WORD = 3'b010, MEM_BYTE_U = 3'b100, MEM_HALF_U = 3'b101
    } mem_access_e;

    typedef struct packed {
        logic [opcode_w-1:0] opcode;
        logic [funct3_w-1:0] funct3;
        logic [funct7_w-1:0] funct7;
    } inst_fields_t;

    typedef struct packed {
        alu_op_e  alu_op;   // Bits 16:12
        op1_sel_e op1_sel;
        op2_sel_e op2_sel;
        pc_sel_e  pc_sel;   // Overridden for branches
        logic     rf_we;
        logic     mem_en;
        logic     mem_wen;
        wb_sel_e  wb_sel;   // Bits 1:0
    } ctrl_word_t;

    typedef struct packed {
        logic eq;           // rs1 == rs2
        logic lt;           // Signed rs1 < rs2
        logic ltu;          // Unsigned rs1 < rs2
    } br_flags_t;

    typedef struct packed {logic [ctrl_key_w-1:0] key; ctrl_word_t data;} ctrl_entry_t;
    typedef struct packed {logic [mem_key_w-1:0] key; mem_access_e data;} mem_entry_t;
    typedef ctrl_entry_t [nr_ctrl_keys-1:0] ctrl_table_t;
    typedef mem_entry_t [nr_mem_keys-1:0] mem_table_t;

    // Register-writing ALU word, only the op and operand 2 source differ
    function automatic ctrl_word_t alu_word(alu_op_e op, op2_sel_e src);
        return '{op, OP1_RS1, src, PC_SEQ, 1'b1, 1'b0, 1'b0, WB_ALU};
    endfunction

    localparam ctrl_word_t load_word   = '{ALU_ADD, OP1_RS1, OP2_IMM_I, PC_SEQ, 1'b1, 1'b1, 1'b0, WB_MEM};
    localparam ctrl_word_t store_word  = '{ALU_ADD, OP1_RS1, OP2_IMM_S, PC_SEQ, 1'b0, 1'b1, 1'b1, WB_NONE};
    localparam ctrl_word_t branch_word = '{ALU_ADD, OP1_RS1, OP2_NONE, PC_SEQ, 1'b0, 1'b0, 1'b0, WB_ALU};
    localparam ctrl_word_t jal_word    = '{ALU_ADD, OP1_RS1, OP2_NONE, PC_JAL_TGT, 1'b1, 1'b0, 1'b0, WB_PC4};
    localparam ctrl_word_t jalr_word   = '{ALU_ADD, OP1_RS1, OP2_IMM_I, PC_JALR_TGT, 1'b1, 1'b0, 1'b0, WB_PC4};
    localparam ctrl_word_t auipc_word  = '{ALU_ADD, OP1_PC, OP2_NONE, PC_SEQ, 1'b1, 1'b0, 1'b0, WB_ALU};

    localparam ctrl_table_t ctrl_table = '{
        '{{OPC_OP, 3'b000, 7'h00}, alu_word(ALU_ADD, OP2_RS2)},       // ADD
        '{{OPC_OP, 3'b000, 7'h20}, alu_word(ALU_SUB, OP2_RS2)},       // SUB
        '{{OPC_OP, 3'b001, 7'h00}, alu_word(ALU_SLL, OP2_RS2)},
        '{{OPC_OP, 3'b010, 7'h00}, alu_word(ALU_SLT, OP2_RS2)},
        '{{OPC_OP, 3'b011, 7'h00}, alu_word(ALU_SLTU, OP2_RS2)},
        '{{OPC_OP, 3'b100, 7'h00}, alu_word(ALU_XOR, OP2_RS2)},
        '{{OPC_OP, 3'b101, 7'h00}, alu_word(ALU_SRL, OP2_RS2)},
        '{{OPC_OP, 3'b101, 7'h20}, alu_word(ALU_SRA, OP2_RS2)},       // SRA
        '{{OPC_OP, 3'b110, 7'h00}, alu_word(ALU_OR, OP2_RS2)},
        '{{OPC_OP, 3'b111, 7'h00}, alu_word(ALU_AND, OP2_RS2)},
        '{{OPC_OP_IMM, 3'b000, 7'h00}, alu_word(ALU_ADD, OP2_IMM_I)}, // ADDI
        '{{OPC_OP_IMM, 3'b010, 7'h00}, alu_word(ALU_SLT, OP2_IMM_I)},
        '{{OPC_OP_IMM, 3'b011, 7'h00}, alu_word(ALU_SLTU, OP2_IMM_I)},
        '{{OPC_OP_IMM, 3'b100, 7'h00}, alu_word(ALU_XOR, OP2_IMM_I)},
        '{{OPC_OP_IMM, 3'b110, 7'h00}, alu_word(ALU_OR, OP2_IMM_I)},
        '{{OPC_OP_IMM, 3'b111, 7'h00}, alu_word(ALU_AND, OP2_IMM_I)},
        '{{OPC_OP_IMM, 3'b001, 7'h00}, alu_word(ALU_SLL, OP2_IMM_I)},
        '{{OPC_OP_IMM, 3'b101, 7'h00}, alu_word(ALU_SRL, OP2_IMM_I)},
        '{{OPC_OP_IMM, 3'b101, 7'h20}, alu_word(ALU_SRA, OP2_IMM_I)}, // SRAI
        '{{OPC_LOAD, 3'b010, 7'h00}, load_word},                      // LW
        '{{OPC_LOAD, 3'b000, 7'h00}, load_word},
        '{{OPC_LOAD, 3'b100, 7'h00}, load_word},
        '{{OPC_LOAD, 3'b001, 7'h00}, load_word},
        '{{OPC_LOAD, 3'b101, 7'h00}, load_word},                      // LHU
        '{{OPC_BRANCH, 3'b000, 7'h00}, branch_word},                  // BEQ
        '{{OPC_BRANCH, 3'b001, 7'h00}, branch_word},
        '{{OPC_BRANCH, 3'b100, 7'h00}, branch_word},
        '{{OPC_BRANCH, 3'b101, 7'h00}, branch_word},
        '{{OPC_BRANCH, 3'b110, 7'h00}, branch_word},
        '{{OPC_BRANCH, 3'b111, 7'h00}, branch_word},                  // BGEU
        '{{OPC_JAL, 3'b000, 7'h00}, jal_word},
        '{{OPC_AUIPC, 3'b000, 7'h00}, auipc_word},
        '{{OPC_STORE, 3'b010, 7'h00}, store_word},                    // SW
        '{{OPC_STORE, 3'b000, 7'h00}, store_word},
        '{{OPC_STORE, 3'b001, 7'h00}, store_word},
        '{{OPC_JALR, 3'b000, 7'h00}, jalr_word},
        '{{OPC_SYSTEM, 3'b000, 7'h00}, ctrl_word_t'('0)}              // EBREAK, no datapath action
    };

    localparam mem_table_t mem_table = '{
        '{{OPC_LOAD, 3'b010}, MEM_WORD},
        '{{OPC_LOAD, 3'b000}, MEM_BYTE},
        '{{OPC_LOAD, 3'b100}, MEM_BYTE_U},
        '{{OPC_LOAD, 3'b001}, MEM_HALF},
        '{{OPC_LOAD, 3'b101}, MEM_HALF_U},
        '{{OPC_STORE, 3'b010}, MEM_WORD},
        '{{OPC_STORE, 3'b000}, MEM_BYTE},
        '{{OPC_STORE, 3'b001}, MEM_HALF}
    };

endpackage

// File: src/inst_classifier.sv
// Splits an RV32I instruction into decode fields and builds the normalized control lookup key
`timescale 1ns/1ps

module inst_classifier
    import rv32_ctrl_pkg::*;
(
    input  logic [xlen-1:0]       inst,
    output inst_fields_t          fields,
    output logic [ctrl_key_w-1:0] ctrl_key,
    output logic                  is_ebreak
);

    localparam logic [xlen-1:0]     ebreak_inst     = 32'h0010_0073;
    localparam logic [funct7_w-1:0] jalr_nomatch_f7 = 7'b1101111;    // No table entry carries this

    logic [funct3_w-1:0] key_f3;  // Normalized funct3
    logic [funct7_w-1:0] key_f7;  // Normalized funct7

    assign fields = '{
        opcode: inst[6:0],
        funct3: inst[14:12],
        funct7: inst[31:25]
    };

    always_comb begin
        key_f3 = fields.funct3;                   // Raw fields unless the opcode says otherwise
        key_f7 = fields.funct7;
        case (fields.opcode)
            OPC_JALR: begin
                key_f7 = (fields.funct3 == 3'b000) ? '0 : jalr_nomatch_f7; // Only JALR f3=0 is legal
            end
            OPC_OP_IMM: begin
                if (fields.funct3 != 3'b101) begin
                    key_f7 = '0;                  // funct7 is immediate bits here
                end
            end
            OPC_AUIPC, OPC_JAL: begin
                key_f3 = '0;                      // All upper bits are immediate
                key_f7 = '0;
            end
            OPC_LOAD, OPC_STORE, OPC_BRANCH: begin
                key_f7 = '0;                      // Immediate bits
            end
            default: begin
            end
        endcase
    end

    assign ctrl_key  = {fields.opcode, key_f3, key_f7};
    assign is_ebreak = (inst == ebreak_inst);     // Exact encoding match only

endmodule

// File: src/key_lut.sv
// Keyed lookup over a constant table, returns the matching payload or zero on a miss
`timescale 1ns/1ps

module key_lut #(
    parameter int  nr_keys = 2,
    parameter int  key_w   = 1,
    parameter type data_t  = logic,
    // Each entry is {key, payload}, key in the upper bits
    parameter logic [nr_keys-1:0][key_w+$bits(data_t)-1:0] lut_table = '0
) (
    input  logic [key_w-1:0] key,
    output data_t            data
);

    localparam int data_w  = $bits(data_t);
    localparam int entry_w = key_w + data_w;

    logic [data_w-1:0] data_or;  // OR of all hit payloads

    always_comb begin
        data_or = '0;
        for (int i = 0; i < nr_keys; i++) begin
            if (lut_table[i][entry_w-1 -: key_w] == key) begin    // Keys are unique
                data_or = data_or | lut_table[i][data_w-1:0];
            end
        end
    end

    assign data = data_t'(data_or);  // Zero on miss

endmodule

// File: src/branch_resolver.sv
// Resolves the next-PC select of conditional branches from funct3 and the compare flags
`timescale 1ns/1ps

module branch_resolver
    import rv32_ctrl_pkg::*;
(
    input  ctrl_word_t   table_ctrl,
    input  inst_fields_t fields,
    input  br_flags_t    br_flags,
    output ctrl_word_t   ctrl
);

    logic taken;  // Branch condition holds

    always_comb begin
        case (fields.funct3)
            3'b000:  taken = br_flags.eq;         // BEQ
            3'b001:  taken = ~br_flags.eq;        // BNE
            3'b100:  taken = br_flags.lt;         // BLT
            3'b101:  taken = ~br_flags.lt;        // BGE
            3'b110:  taken = br_flags.ltu;        // BLTU
            3'b111:  taken = ~br_flags.ltu;       // BGEU
            default: taken = 1'b0;                // 010 and 011 never branch
        endcase
    end

    always_comb begin
        ctrl = table_ctrl;                        // Everything but pc_sel passes through
        if (fields.opcode == OPC_BRANCH) begin
            ctrl.pc_sel = taken ? PC_BRANCH_TGT : PC_SEQ;
        end
    end

endmodule

// File: src/rv32_ctrl_decoder.sv
// Top level of the single-cycle RV32I control decoder, instruction and flags in, control word out
`timescale 1ns/1ps

module rv32_ctrl_decoder
    import rv32_ctrl_pkg::*;
#(
    parameter ctrl_table_t ctrl_table = rv32_ctrl_pkg::ctrl_table,  // Control word table
    parameter mem_table_t  mem_table  = rv32_ctrl_pkg::mem_table    // Access size table
) (
    input  logic [xlen-1:0] inst,
    input  br_flags_t       br_flags,
    output ctrl_word_t      ctrl,
    output mem_access_e     mem_access,
    output logic            is_ebreak
);

    inst_fields_t          fields;      // Raw opcode, funct3, funct7
    logic [ctrl_key_w-1:0] ctrl_key;    // Normalized control key
    ctrl_word_t            table_ctrl;  // Before branch resolution

    inst_classifier classifier_i (
        .inst      (inst),
        .fields    (fields),
        .ctrl_key  (ctrl_key),
        .is_ebreak (is_ebreak)
    );

    key_lut #(
        .nr_keys   (nr_ctrl_keys),
        .key_w     (ctrl_key_w),
        .data_t    (ctrl_word_t),
        .lut_table (ctrl_table)
    ) ctrl_lut_i (
        .key  (ctrl_key),
        .data (table_ctrl)
    );

    key_lut #(
        .nr_keys   (nr_mem_keys),
        .key_w     (mem_key_w),
        .data_t    (mem_access_e),
        .lut_table (mem_table)
    ) mem_lut_i (
        .key  ({fields.opcode, fields.funct3}),  // funct7 plays no part in access size
        .data (mem_access)
    );

    branch_resolver branch_i (
        .table_ctrl (table_ctrl),
        .fields     (fields),
        .br_flags   (br_flags),
        .ctrl       (ctrl)
    );

endmodule

// File: include/ctrl_ref_model.svh
// Testbench reference model of the decode rules, included inside a module that imports rv32_ctrl_pkg
`ifndef CTRL_REF_MODEL_SVH
`define CTRL_REF_MODEL_SVH

// Register or immediate ALU instruction, zero word when funct7 is not legal
function automatic ctrl_word_t ref_alu_word(logic [2:0] f3, logic [6:0] f7, logic is_reg);
    ctrl_word_t w;
    alu_op_e    op;
    logic       f7_ok;
    w     = '0;
    f7_ok = !is_reg || (f7 == 7'h00);  // Immediate forms ignore funct7 by default
    case (f3)
        3'b000: begin
            op    = (is_reg && f7 == 7'h20) ? ALU_SUB : ALU_ADD;
            f7_ok = !is_reg || (f7 == 7'h00) || (f7 == 7'h20);
        end
        3'b001: op = ALU_SLL;
        3'b010: op = ALU_SLT;
        3'b011: op = ALU_SLTU;
        3'b100: op = ALU_XOR;
        3'b101: begin
            op    = (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
            f7_ok = (f7 == 7'h00) || (f7 == 7'h20);  // Shift type checked in both forms
        end
        3'b110: op = ALU_OR;
        default: op = ALU_AND;
    endcase
    if (f7_ok) begin
        w.alu_op  = op;
        w.op2_sel = is_reg ? OP2_RS2 : OP2_IMM_I;
        w.rf_we   = 1'b1;
        w.wb_sel  = WB_ALU;
    end
    return w;
endfunction

function automatic logic ref_branch_taken(logic [2:0] f3, br_flags_t flags);
    case (f3)
        3'b000:  return flags.eq;
        3'b001:  return !flags.eq;
        3'b100:  return flags.lt;
        3'b101:  return !flags.lt;
        3'b110:  return flags.ltu;
        3'b111:  return !flags.ltu;
        default: return 1'b0;
    endcase
endfunction

function automatic ctrl_word_t ref_ctrl(logic [31:0] inst, br_flags_t flags);
    ctrl_word_t w;
    logic [6:0] opc;
    logic [2:0] f3;
    opc = inst[6:0];
    f3  = inst[14:12];
    w   = '0;  // Anything not listed decodes to zero
    case (opc)
        OPC_OP:     w = ref_alu_word(f3, inst[31:25], 1'b1);
        OPC_OP_IMM: w = ref_alu_word(f3, inst[31:25], 1'b0);
        OPC_LOAD: begin
            if (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                w.op2_sel = OP2_IMM_I;
                w.rf_we   = 1'b1;
                w.mem_en  = 1'b1;
                w.wb_sel  = WB_MEM;
            end
        end
        OPC_STORE: begin
            if (f3 <= 3'b010) begin
                w.op2_sel = OP2_IMM_S;
                w.mem_en  = 1'b1;
                w.mem_wen = 1'b1;
            end
        end
        OPC_BRANCH: begin
            if (f3 != 3'b010 && f3 != 3'b011) begin
                w.wb_sel = WB_ALU;
                w.pc_sel = ref_branch_taken(f3, flags) ? PC_BRANCH_TGT : PC_SEQ;
            end
        end
        OPC_JAL: begin
            w.pc_sel = PC_JAL_TGT;
            w.rf_we  = 1'b1;
            w.wb_sel = WB_PC4;
        end
        OPC_JALR: begin
            if (f3 == 3'b000) begin
                w.op2_sel = OP2_IMM_I;
                w.pc_sel  = PC_JALR_TGT;
                w.rf_we   = 1'b1;
                w.wb_sel  = WB_PC4;
            end
        end
        OPC_AUIPC: begin
            w.op1_sel = OP1_PC;
            w.rf_we   = 1'b1;
            w.wb_sel  = WB_ALU;
        end
        default: begin
        end
    endcase
    return w;
endfunction

// Access size is funct3 itself for legal loads and stores
function automatic mem_access_e ref_mem_access(logic [31:0] inst);
    logic [2:0] f3;
    f3 = inst[14:12];
    if ((inst[6:0] == OPC_LOAD && f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) ||
        (inst[6:0] == OPC_STORE && f3 <= 3'b010)) begin
        return mem_access_e'(f3);
    end
    return mem_access_e'(3'b000);
endfunction

function automatic logic ref_is_ebreak(logic [31:0] inst);
    return inst == 32'h0010_0073;
endfunction

`endif

// File: verification/rv32_ctrl_decoder_tb.sv
// Simulation top checking the control decoder against a reference model on random instructions
`timescale 1ns/1ps

module rv32_ctrl_decoder_tb
    import rv32_ctrl_pkg::*;
();

    localparam int          n_alu         = 200;
    localparam int          n_mem         = 80;  // Five passes over load and store funct3
    localparam int          n_branch      = 64;  // Every funct3 times every flag set
    localparam int          n_jump        = 64;
    localparam int          n_system      = 64;
    localparam int          total_vectors = n_alu + n_mem + n_branch + n_jump + n_system;
    localparam longint      watchdog_ns   = longint'(total_vectors) * 100 * 2;
    localparam logic [31:0] ebreak_inst   = 32'h0010_0073;
    localparam logic [6:0]  opc_lui       = 7'b0110111;  // No table entry

    logic            clk;
    logic            arst_n;
    logic [xlen-1:0] inst;
    br_flags_t       br_flags;
    ctrl_word_t      ctrl;
    mem_access_e     mem_access;
    logic            is_ebreak;

    integer seed        = 32'h0d3e5e8f;
    int     err_count   = 0;
    int     check_count = 0;
    int     test_count  = 0;

    logic [6:0] known_opcodes [0:8] = '{OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH,
                                        OPC_JAL, OPC_JALR, OPC_AUIPC, OPC_SYSTEM};

    `include "ctrl_ref_model.svh"

    rv32_ctrl_decoder dut_i (
        .inst       (inst),
        .br_flags   (br_flags),
        .ctrl       (ctrl),
        .mem_access (mem_access),
        .is_ebreak  (is_ebreak)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic br_flags_t rand_flags();
        logic [31:0] r;
        r = rand_word();
        return br_flags_t'(r[2:0]);
    endfunction

    // Random funct7 one time in four
    function automatic logic [6:0] pick_funct7();
        logic [31:0] r;
        r = rand_word();
        case (r[1:0])
            2'b00, 2'b01: return 7'h00;
            2'b10:        return 7'h20;
            default:      return r[14:8];
        endcase
    endfunction

    function automatic logic [6:0] pick_opcode();
        logic [31:0] r;
        logic [3:0]  idx;
        r   = rand_word();
        idx = 4'(r[31:8] % 9);
        if (r[3:0] == 4'h0) begin
            return r[10:4];                         // Occasional raw opcode
        end
        return known_opcodes[idx];
    endfunction

    // Register and immediate bits random
    function automatic logic [31:0] make_inst(logic [6:0] opc, logic [2:0] f3, logic [6:0] f7);
        logic [31:0] r;
        r = rand_word();
        return {f7, r[24:15], f3, r[11:7], opc};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            err_count++;
            $display("CHECK FAILED %s: expected 0x%h, got 0x%h, inst 0x%h",
                     name, expected, actual, inst);
        end
    endtask

    task automatic apply_vector(input logic [31:0] vec_inst, input br_flags_t vec_flags);
        ctrl_word_t  exp_ctrl;
        mem_access_e exp_mem;
        logic        exp_ebreak;
        @(negedge clk);
        inst     = vec_inst;
        br_flags = vec_flags;
        @(posedge clk);                             // Outputs settled half a cycle ago
        exp_ctrl   = ref_ctrl(vec_inst, vec_flags);
        exp_mem    = ref_mem_access(vec_inst);
        exp_ebreak = ref_is_ebreak(vec_inst);
        check_value("ctrl", {15'b0, exp_ctrl}, {15'b0, ctrl});
        check_value("mem_access", {29'b0, exp_mem}, {29'b0, mem_access});
        check_value("is_ebreak", {31'b0, exp_ebreak}, {31'b0, is_ebreak});
    endtask

    task automatic report_test(input string name, input int vectors, input int errs_before);
        test_count++;
        $display("Test %0d %s: %0d vectors, %0d errors",
                 test_count, name, vectors, err_count - errs_before);
    endtask

    task automatic test_alu();
        int          errs_before;
        logic [31:0] r;
        logic [6:0]  opc;
        errs_before = err_count;
        for (int i = 0; i < n_alu; i++) begin
            r   = rand_word();
            opc = r[0] ? OPC_OP : OPC_OP_IMM;
            apply_vector(make_inst(opc, r[3:1], pick_funct7()), rand_flags());
        end
        report_test("alu", n_alu, errs_before);
    endtask

    task automatic test_mem();
        int          errs_before;
        logic [31:0] r;
        logic [6:0]  opc;
        errs_before = err_count;
        for (int i = 0; i < n_mem; i++) begin
            r   = rand_word();
            opc = i[3] ? OPC_STORE : OPC_LOAD;
            apply_vector(make_inst(opc, i[2:0], r[6:0]), rand_flags()); // funct7 is offset bits
        end
        report_test("load_store", n_mem, errs_before);
    endtask

    task automatic test_branch();
        int          errs_before;
        logic [31:0] r;
        errs_before = err_count;
        for (int i = 0; i < n_branch; i++) begin
            r = rand_word();
            apply_vector(make_inst(OPC_BRANCH, i[5:3], r[6:0]), br_flags_t'(i[2:0]));
        end
        report_test("branch", n_branch, errs_before);
    endtask

    task automatic test_jumps();
        int          errs_before;
        logic [31:0] r;
        logic [31:0] vec;
        errs_before = err_count;
        for (int i = 0; i < n_jump; i++) begin
            r = rand_word();
            case (i % 4)
                0:       vec = make_inst(OPC_JAL, r[2:0], r[9:3]);   // funct3, funct7 ignored
                1:       vec = make_inst(OPC_JALR, 3'b000, r[9:3]);
                2:       vec = make_inst(OPC_AUIPC, r[2:0], r[9:3]);
                default: vec = make_inst(OPC_JALR, (r[2:0] == 3'b000) ? 3'b001 : r[2:0], r[9:3]);
            endcase
            apply_vector(vec, rand_flags());
        end
        report_test("jumps", n_jump, errs_before);
    endtask

    task automatic test_system();
        int          errs_before;
        logic [31:0] r;
        logic [31:0] vec;
        errs_before = err_count;
        for (int i = 0; i < n_system; i++) begin
            r = rand_word();
            if (i == 0) begin
                vec = ebreak_inst;                  // Exact match once
            end else begin
                case (i % 4)
                    1:       vec = ebreak_inst ^ (32'h1 << r[4:0]);     // Single bit off
                    2:       vec = make_inst(OPC_SYSTEM, r[2:0], r[9:3]);
                    3:       vec = make_inst(opc_lui, r[2:0], r[9:3]);
                    default: vec = make_inst(pick_opcode(), r[2:0], pick_funct7());
                endcase
                if (vec == ebreak_inst) begin
                    vec = vec ^ 32'h8000_0000;
                end
            end
            apply_vector(vec, rand_flags());
        end
        report_test("system", n_system, errs_before);
    endtask

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);                  // Hold reset 5 cycles
        arst_n = 1'b1;
    end

    initial begin
        inst     = '0;
        br_flags = '0;
        wait (arst_n === 1'b1);                     // Stimulus starts once reset lifts
        test_alu();
        test_mem();
        test_branch();
        test_jumps();
        test_system();
        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);                             // Twice the vector run time
        $display("Watchdog expired after %0d ns before all tests finished", watchdog_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: rv32_ctrl_decoder.f
+incdir+include
src/rv32_ctrl_pkg.sv
src/inst_classifier.sv
src/key_lut.sv
src/branch_resolver.sv
src/rv32_ctrl_decoder.sv
verification/rv32_ctrl_decoder_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the RV32I control decoder testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f rv32_ctrl_decoder.f \
    --top-module rv32_ctrl_decoder_tb \
    --Mdir obj_dir \
    -o sim_rv32_ctrl_decoder

output=$(./obj_dir/sim_rv32_ctrl_decoder)
echo "$output"

if echo "$output" | grep -qF -- '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
